/* project.f */
lc3b_pkg.sv
lc3b_control.sv
lc3b_regfile.sv
lc3b_pipe_reg.sv
lc3b_forwarding.sv
lc3b_hazard.sv
lc3b_datapath.sv
lc3b_cpu.sv
tb_lc3b_cpu.sv

/* run.sh */
#!/bin/sh
# compile and run the lc3b core testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_lc3b_cpu -o sim_lc3b
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_lc3b > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

/* tb_lc3b_cpu.sv */
`timescale 1ns/1ps

module tb_lc3b_cpu;

    localparam int          SEED     = 53839;
    localparam int          MAX_WAIT = 3;
    localparam logic [3:0]  OPC_ADD  = 4'h1;
    localparam logic [3:0]  OPC_AND  = 4'h5;
    localparam logic [3:0]  OPC_LDR  = 4'h6;
    localparam logic [3:0]  OPC_STR  = 4'h7;

    logic        clk;
    logic        i_rst_n;
    logic        o_imem_read;
    logic [15:0] o_imem_addr;
    logic        i_imem_resp;
    logic [15:0] i_imem_rdata;
    logic        o_dmem_read;
    logic        o_dmem_write;
    logic [15:0] o_dmem_addr;
    logic [15:0] o_dmem_wdata;
    logic        i_dmem_resp;
    logic [15:0] i_dmem_rdata;

    // program rows, expected stores, observed stores
    logic [15:0] prog_ir[$];
    string       prog_note[$];
    logic [15:0] exp_addr[$];
    logic [15:0] exp_data[$];
    logic [15:0] obs_addr[$];
    logic [15:0] obs_data[$];
    logic [15:0] dmem [256];

    lc3b_cpu u_dut (
        .clk, .i_rst_n,
        .o_imem_read, .o_imem_addr, .i_imem_resp, .i_imem_rdata,
        .o_dmem_read, .o_dmem_write, .o_dmem_addr, .o_dmem_wdata,
        .i_dmem_resp, .i_dmem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // instruction encoders for the lc-3b formats
    function automatic logic [15:0] reg_op(logic [3:0] opc, int dr, int s1, int s2);
        return {opc, dr[2:0], s1[2:0], 3'b000, s2[2:0]};
    endfunction

    function automatic logic [15:0] imm_op(logic [3:0] opc, int dr, int s1, int imm);
        return {opc, dr[2:0], s1[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic logic [15:0] not_op(int dr, int sr);
        return {4'h9, dr[2:0], sr[2:0], 6'b111111};
    endfunction

    // ldr and str, offset6 counts words
    function automatic logic [15:0] mem_op(logic [3:0] opc, int r, int base, int off);
        return {opc, r[2:0], base[2:0], off[5:0]};
    endfunction

    function automatic logic [15:0] br_op(int nzp, int off);
        return {4'h0, nzp[2:0], off[8:0]};
    endfunction

    function automatic logic [15:0] lea_op(int dr, int off);
        return {4'he, dr[2:0], off[8:0]};
    endfunction

    // background pattern for data memory words
    function automatic logic [15:0] fill_word(logic [7:0] idx);
        return {~idx, idx};
    endfunction

    // past the end of the program the rom reads as BR never
    function automatic logic [15:0] rom_word(logic [15:0] addr);
        int idx;
        idx = {17'd0, addr[15:1]};
        if (idx < prog_ir.size()) begin
            return prog_ir[idx];
        end
        return 16'h0000;
    endfunction

    function automatic int draw_wait();
        return $urandom_range(MAX_WAIT, 0);
    endfunction

    task automatic emit(logic [15:0] ir, string note);
        prog_ir.push_back(ir);
        prog_note.push_back(note);
    endtask

    task automatic expect_store(logic [15:0] addr, logic [15:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic build_program();
        emit(imm_op(OPC_ADD, 1, 0, 5),   "r1 = 5");
        emit(imm_op(OPC_ADD, 2, 1, -3),  "r2 = r1 - 3, r1 from mem");
        emit(reg_op(OPC_ADD, 3, 2, 1),   "r3 = r2 + r1, mem and wb");
        emit(imm_op(OPC_AND, 4, 3, 6),   "r4 = r3 & 6");
        emit(not_op(5, 4),               "r5 = ~r4");
        emit(reg_op(OPC_AND, 6, 5, 3),   "r6 = r5 & r3");
        emit(mem_op(OPC_STR, 6, 0, 5),   "[0x0a] = r6, data from mem");
        emit(mem_op(OPC_STR, 1, 0, 0),   "[0x00] = r1");
        emit(mem_op(OPC_STR, 2, 0, 1),   "[0x02] = r2");
        emit(mem_op(OPC_STR, 3, 0, 2),   "[0x04] = r3");
        emit(mem_op(OPC_STR, 4, 0, 3),   "[0x06] = r4");
        emit(mem_op(OPC_STR, 5, 0, 4),   "[0x08] = r5");
        emit(mem_op(OPC_LDR, 1, 0, 31),  "r1 = [0x3e]");
        emit(imm_op(OPC_ADD, 2, 1, 4),   "r2 = r1 + 4, load-use");
        emit(mem_op(OPC_STR, 2, 0, 6),   "[0x0c] = r2");
        emit(imm_op(OPC_ADD, 3, 0, 0),   "r3 = 0, cc z");
        emit(br_op(3'b010, 2),           "brz taken");
        emit(mem_op(OPC_STR, 1, 0, 7),   "skipped");
        emit(mem_op(OPC_STR, 1, 0, 8),   "skipped");
        emit(br_op(3'b101, 2),           "brnp not taken");
        emit(mem_op(OPC_STR, 4, 0, 9),   "[0x12] = r4");
        emit(mem_op(OPC_STR, 5, 0, 10),  "[0x14] = r5");
        emit(lea_op(7, 5),               "r7 = 0x2e + 10");
        emit(mem_op(OPC_STR, 7, 0, 11),  "[0x16] = r7");
        emit(lea_op(6, -4),              "r6 = 0x32 - 8");
        emit(mem_op(OPC_STR, 6, 0, 12),  "[0x18] = r6");
        emit(mem_op(OPC_LDR, 2, 0, 9),   "r2 = [0x12]");
        emit(mem_op(OPC_STR, 2, 0, 13),  "[0x1a] = r2, load-use on store data");
    endtask

    task automatic build_expected();
        expect_store(16'h000a, 16'h0001);
        expect_store(16'h0000, 16'h0005);
        expect_store(16'h0002, 16'h0002);
        expect_store(16'h0004, 16'h0007);
        expect_store(16'h0006, 16'h0006);
        expect_store(16'h0008, 16'hfff9);
        // fill at word 0x1f is 0xe01f
        expect_store(16'h000c, 16'he023);
        expect_store(16'h0012, 16'h0006);
        expect_store(16'h0014, 16'hfff9);
        expect_store(16'h0016, 16'h0038);
        expect_store(16'h0018, 16'h002a);
        expect_store(16'h001a, 16'h0006);
    endtask

    // instruction memory, resp after a random number of waits
    initial begin
        int          cnt;
        logic        pend;
        logic [15:0] addr_q;
        i_imem_resp  = 1'b0;
        i_imem_rdata = 16'h0000;
        cnt          = -1;
        pend         = 1'b0;
        addr_q       = 16'h0000;
        forever begin
            @(negedge clk);
            if (i_imem_resp) begin
                cnt = -1;
            end
            i_imem_resp = 1'b0;
            if (pend) begin
                check_value("o_imem_read", {15'd0, o_imem_read}, 16'd1);
                check_value("o_imem_addr", o_imem_addr, addr_q);
            end
            pend = 1'b0;
            if (i_rst_n && o_imem_read) begin
                if (cnt < 0) begin
                    cnt = draw_wait();
                end
                if (cnt == 0) begin
                    i_imem_resp  = 1'b1;
                    i_imem_rdata = rom_word(o_imem_addr);
                end else begin
                    cnt    = cnt - 1;
                    pend   = 1'b1;
                    addr_q = o_imem_addr;
                end
            end
        end
    end

    // data memory, stores are queued for the checking loop
    initial begin
        int          cnt;
        logic        pend;
        logic [15:0] strobe_q;
        logic [15:0] addr_q;
        logic [15:0] data_q;
        i_dmem_resp  = 1'b0;
        i_dmem_rdata = 16'h0000;
        cnt          = -1;
        pend         = 1'b0;
        strobe_q     = 16'd0;
        addr_q       = 16'h0000;
        data_q       = 16'h0000;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i[7:0]);
        end
        forever begin
            @(negedge clk);
            if (i_dmem_resp) begin
                cnt = -1;
            end
            i_dmem_resp = 1'b0;
            if (pend) begin
                check_value("o_dmem_read/write", {14'd0, o_dmem_read, o_dmem_write},
                            strobe_q);
                check_value("o_dmem_addr", o_dmem_addr, addr_q);
                if (o_dmem_write) begin
                    check_value("o_dmem_wdata", o_dmem_wdata, data_q);
                end
            end
            pend = 1'b0;
            if (i_rst_n && (o_dmem_read || o_dmem_write)) begin
                if (cnt < 0) begin
                    cnt = draw_wait();
                end
                if (cnt == 0) begin
                    i_dmem_resp = 1'b1;
                    if (o_dmem_write) begin
                        dmem[o_dmem_addr[8:1]] = o_dmem_wdata;
                        obs_addr.push_back(o_dmem_addr);
                        obs_data.push_back(o_dmem_wdata);
                    end else begin
                        i_dmem_rdata = dmem[o_dmem_addr[8:1]];
                    end
                end else begin
                    cnt      = cnt - 1;
                    pend     = 1'b1;
                    strobe_q = {14'd0, o_dmem_read, o_dmem_write};
                    addr_q   = o_dmem_addr;
                    data_q   = o_dmem_wdata;
                end
            end
        end
    end

    // bound grows with program length and the longest memory wait
    initial begin
        int limit;
        @(posedge i_rst_n);
        limit = prog_ir.size() * 64 * (MAX_WAIT + 1);
        repeat (limit) @(posedge clk);
        $display("core hung: stores still missing after %0d cycles", limit);
        $display("** FAIL **");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(SEED));
        i_rst_n = 1'b0;
        build_program();
        build_expected();
        for (int i = 0; i < prog_ir.size(); i++) begin
            $display("%04h: %04h  %s", 2 * i, prog_ir[i], prog_note[i]);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        for (int i = 0; i < exp_addr.size(); i++) begin
            while (obs_addr.size() == 0) begin
                @(posedge clk);
            end
            check_value("o_dmem_addr", obs_addr.pop_front(), exp_addr[i]);
            check_value("o_dmem_wdata", obs_data.pop_front(), exp_data[i]);
        end

        // nothing may be stored after the last row
        repeat (32) @(posedge clk);
        check_value("extra stores", 16'(obs_addr.size()), 16'd0);
        $display("** PASS **");
        $finish;
    end

endmodule : tb_lc3b_cpu

/* lc3b_cpu.sv */
`timescale 1ns/1ps

module lc3b_cpu (
    input  logic               clk,
    input  logic               i_rst_n,
    // instruction memory
    output logic               o_imem_read,
    output lc3b_pkg::lc3b_word o_imem_addr,
    input  logic               i_imem_resp,
    input  lc3b_pkg::lc3b_word i_imem_rdata,
    // data memory
    output logic               o_dmem_read,
    output logic               o_dmem_write,
    output lc3b_pkg::lc3b_word o_dmem_addr,
    output lc3b_pkg::lc3b_word o_dmem_wdata,
    input  logic               i_dmem_resp,
    input  lc3b_pkg::lc3b_word i_dmem_rdata
);

    import lc3b_pkg::*;

    lc3b_control_word cw;
    lc3b_opcode       opcode;
    logic             ir_5;
    logic             load, stall_id, flush, load_ex, br_taken, wr_mem, wr_wb;
    lc3b_fwd_sel      fwd_a, fwd_b;
    lc3b_reg          src1_id, src2_id, src1_ex, src2_ex, dest_ex, dest_mem, dest_wb;

    lc3b_control u_control (
        .i_opcode(opcode),
        .i_ir_5  (ir_5),
        .o_cw    (cw)
    );

    lc3b_datapath u_datapath (
        .clk, .i_rst_n,
        .i_cw        (cw),
        .o_opcode    (opcode),
        .o_ir_5      (ir_5),
        .o_imem_read, .o_imem_addr, .i_imem_resp, .i_imem_rdata,
        .o_dmem_read, .o_dmem_write, .o_dmem_addr, .o_dmem_wdata,
        .i_dmem_resp, .i_dmem_rdata,
        .i_load      (load),
        .i_stall_id  (stall_id),
        .i_flush     (flush),
        .i_fwd_a     (fwd_a),
        .i_fwd_b     (fwd_b),
        .o_src1_id   (src1_id),
        .o_src2_id   (src2_id),
        .o_src1_ex   (src1_ex),
        .o_src2_ex   (src2_ex),
        .o_dest_ex   (dest_ex),
        .o_dest_mem  (dest_mem),
        .o_dest_wb   (dest_wb),
        .o_wr_mem    (wr_mem),
        .o_wr_wb     (wr_wb),
        .o_load_ex   (load_ex),
        .o_br_taken  (br_taken)
    );

    lc3b_hazard u_hazard (
        .i_imem_read (o_imem_read),
        .i_imem_resp,
        .i_dmem_read (o_dmem_read),
        .i_dmem_write(o_dmem_write),
        .i_dmem_resp,
        .i_load_ex   (load_ex),
        .i_dest_ex   (dest_ex),
        .i_src1_id   (src1_id),
        .i_src2_id   (src2_id),
        .i_br_taken  (br_taken),
        .o_load      (load),
        .o_stall_id  (stall_id),
        .o_flush     (flush)
    );

    lc3b_forwarding u_forwarding (
        .i_src1_ex (src1_ex),
        .i_src2_ex (src2_ex),
        .i_dest_mem(dest_mem),
        .i_dest_wb (dest_wb),
        .i_wr_mem  (wr_mem),
        .i_wr_wb   (wr_wb),
        .o_fwd_a   (fwd_a),
        .o_fwd_b   (fwd_b)
    );

endmodule : lc3b_cpu

/* lc3b_datapath.sv */
`timescale 1ns/1ps

module lc3b_datapath (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  lc3b_pkg::lc3b_control_word i_cw,
    output lc3b_pkg::lc3b_opcode       o_opcode,
    output logic                       o_ir_5,
    // instruction memory
    output logic                       o_imem_read,
    output lc3b_pkg::lc3b_word         o_imem_addr,
    input  logic                       i_imem_resp,
    input  lc3b_pkg::lc3b_word         i_imem_rdata,
    // data memory
    output logic                       o_dmem_read,
    output logic                       o_dmem_write,
    output lc3b_pkg::lc3b_word         o_dmem_addr,
    output lc3b_pkg::lc3b_word         o_dmem_wdata,
    input  logic                       i_dmem_resp,
    input  lc3b_pkg::lc3b_word         i_dmem_rdata,
    // hazard and forwarding
    input  logic                       i_load,
    input  logic                       i_stall_id,
    input  logic                       i_flush,
    input  lc3b_pkg::lc3b_fwd_sel      i_fwd_a,
    input  lc3b_pkg::lc3b_fwd_sel      i_fwd_b,
    output lc3b_pkg::lc3b_reg          o_src1_id,
    output lc3b_pkg::lc3b_reg          o_src2_id,
    output lc3b_pkg::lc3b_reg          o_src1_ex,
    output lc3b_pkg::lc3b_reg          o_src2_ex,
    output lc3b_pkg::lc3b_reg          o_dest_ex,
    output lc3b_pkg::lc3b_reg          o_dest_mem,
    output lc3b_pkg::lc3b_reg          o_dest_wb,
    output logic                       o_wr_mem,
    output logic                       o_wr_wb,
    output logic                       o_load_ex,
    output logic                       o_br_taken
);

    import lc3b_pkg::*;

    lc3b_word pc, pc_plus2, fetch_ir, ir_buf, rdata_buf, mdr_in;
    logic     imem_done, dmem_done;

    lc3b_if_id        if_id_d, if_id;
    lc3b_id_ex        id_ex_d, id_ex;
    lc3b_ex_mem       ex_mem_d, ex_mem;
    lc3b_mem_wb       mem_wb_d, mem_wb;
    lc3b_control_word cw_id;
    lc3b_word         rf_a, rf_b;

    lc3b_word pc_rel, op_a, op_b, alu_b, alu_out, mem_val, wb_val;
    lc3b_nzp  cc, cc_ex;

    function automatic lc3b_nzp gencc(lc3b_word v);
        if (v[15]) begin
            return 3'b100;
        end
        return (v == '0) ? 3'b010 : 3'b001;
    endfunction

    function automatic lc3b_word pick(lc3b_fwd_sel sel, lc3b_word rf, lc3b_word m,
                                      lc3b_word w);
        case (sel)
            fwd_mem: return m;
            fwd_wb:  return w;
            default: return rf;
        endcase
    endfunction

    // fetch
    assign pc_plus2 = pc + 16'd2;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc <= PC_RESET;
        end else if (i_load && i_flush) begin
            pc <= pc_rel;
        end else if (i_load && !i_stall_id) begin
            pc <= pc_plus2;
        end
    end

    // an access answered during a freeze is kept until the pipe moves
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_load) begin
            imem_done <= 1'b0;
            dmem_done <= 1'b0;
        end else begin
            if (i_imem_resp) begin
                imem_done <= 1'b1;
            end
            if (i_dmem_resp) begin
                dmem_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_imem_resp) begin
            ir_buf <= i_imem_rdata;
        end
        if (i_dmem_resp) begin
            rdata_buf <= i_dmem_rdata;
        end
    end

    assign o_imem_read = ~imem_done;
    assign o_imem_addr = pc;
    assign fetch_ir    = imem_done ? ir_buf : i_imem_rdata;
    assign if_id_d     = '{pc_plus2: pc_plus2, ir: fetch_ir, valid: 1'b1};

    lc3b_pipe_reg #(
        .payload_t(lc3b_if_id),
        .BUBBLE   (lc3b_if_id'({16'h0000, NOP_IR, 1'b0}))
    ) u_if_id (
        .clk, .i_rst_n,
        .i_load  (i_load & ~i_stall_id),
        .i_bubble(i_flush),
        .i_d     (if_id_d),
        .o_q     (if_id)
    );

    // decode
    assign o_opcode  = lc3b_opcode'(if_id.ir[15:12]);
    assign o_ir_5    = if_id.ir[5];
    assign cw_id     = if_id.valid ? i_cw : '0;
    assign o_src1_id = if_id.ir[8:6];
    // stores read their source register through port b
    assign o_src2_id = cw_id.mem.d_write ? if_id.ir[11:9] : if_id.ir[2:0];

    lc3b_regfile u_regfile (
        .clk, .i_rst_n,
        .i_we   (mem_wb.wb.load_regfile),
        .i_dest (mem_wb.dest),
        .i_wdata(wb_val),
        .i_src_a(o_src1_id),
        .i_src_b(o_src2_id),
        .o_a    (rf_a),
        .o_b    (rf_b)
    );

    always_comb begin
        id_ex_d.cw       = cw_id;
        id_ex_d.pc_plus2 = if_id.pc_plus2;
        id_ex_d.src1     = o_src1_id;
        id_ex_d.src2     = o_src2_id;
        id_ex_d.dest     = if_id.ir[11:9];
        id_ex_d.a        = rf_a;
        id_ex_d.b        = rf_b;
        // offset6 is word scaled for ldr and str, imm5 otherwise
        if (cw_id.mem.d_read || cw_id.mem.d_write) begin
            id_ex_d.imm = {{9{if_id.ir[5]}}, if_id.ir[5:0], 1'b0};
        end else begin
            id_ex_d.imm = {{11{if_id.ir[4]}}, if_id.ir[4:0]};
        end
        id_ex_d.offset = {{6{if_id.ir[8]}}, if_id.ir[8:0], 1'b0};
        id_ex_d.nzp    = if_id.ir[11:9];
    end

    lc3b_pipe_reg #(.payload_t(lc3b_id_ex)) u_id_ex (
        .clk, .i_rst_n,
        .i_load  (i_load),
        .i_bubble(i_stall_id | i_flush),
        .i_d     (id_ex_d),
        .o_q     (id_ex)
    );

    // execute
    assign mem_val = ex_mem.wb.mdr_sel ? mdr_in : ex_mem.alu;
    assign wb_val  = mem_wb.wb.mdr_sel ? mem_wb.mdr : mem_wb.alu;
    assign op_a    = pick(i_fwd_a, id_ex.a, mem_val, wb_val);
    assign op_b    = pick(i_fwd_b, id_ex.b, mem_val, wb_val);
    assign pc_rel  = id_ex.pc_plus2 + id_ex.offset;

    always_comb begin
        if (id_ex.cw.ex.lea_sel) begin
            alu_b = pc_rel;
        end else if (id_ex.cw.ex.alumux_imm) begin
            alu_b = id_ex.imm;
        end else begin
            alu_b = op_b;
        end
        case (id_ex.cw.ex.aluop)
            alu_add: alu_out = op_a + alu_b;
            alu_and: alu_out = op_a & alu_b;
            alu_not: alu_out = ~op_a;
            default: alu_out = alu_b;
        endcase
    end

    // cc as it will be once the older instructions retire
    always_comb begin
        if (ex_mem.wb.load_cc) begin
            cc_ex = gencc(mem_val);
        end else if (mem_wb.wb.load_cc) begin
            cc_ex = gencc(wb_val);
        end else begin
            cc_ex = cc;
        end
    end

    assign o_br_taken = id_ex.cw.ex.branch & |(id_ex.nzp & cc_ex);
    assign ex_mem_d   = '{mem: id_ex.cw.mem, wb: id_ex.cw.wb, dest: id_ex.dest,
                          alu: alu_out, sdata: op_b};

    lc3b_pipe_reg #(.payload_t(lc3b_ex_mem)) u_ex_mem (
        .clk, .i_rst_n,
        .i_load  (i_load),
        .i_bubble(1'b0),
        .i_d     (ex_mem_d),
        .o_q     (ex_mem)
    );

    // memory
    assign o_dmem_read  = ex_mem.mem.d_read & ~dmem_done;
    assign o_dmem_write = ex_mem.mem.d_write & ~dmem_done;
    assign o_dmem_addr  = ex_mem.alu;
    assign o_dmem_wdata = ex_mem.sdata;
    assign mdr_in       = dmem_done ? rdata_buf : i_dmem_rdata;
    assign mem_wb_d     = '{wb: ex_mem.wb, dest: ex_mem.dest, alu: ex_mem.alu, mdr: mdr_in};

    lc3b_pipe_reg #(.payload_t(lc3b_mem_wb)) u_mem_wb (
        .clk, .i_rst_n,
        .i_load  (i_load),
        .i_bubble(1'b0),
        .i_d     (mem_wb_d),
        .o_q     (mem_wb)
    );

    // writeback, the regfile write happens inside u_regfile
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            cc <= CC_RESET;
        end else if (mem_wb.wb.load_cc) begin
            cc <= gencc(wb_val);
        end
    end

    assign o_src1_ex  = id_ex.src1;
    assign o_src2_ex  = id_ex.src2;
    assign o_dest_ex  = id_ex.dest;
    assign o_load_ex  = id_ex.cw.mem.d_read;
    assign o_dest_mem = ex_mem.dest;
    assign o_dest_wb  = mem_wb.dest;
    assign o_wr_mem   = ex_mem.wb.load_regfile;
    assign o_wr_wb    = mem_wb.wb.load_regfile;

    a_dmem_one_strobe: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_dmem_read && o_dmem_write));

    // a pending data access holds its strobe and address until resp
    a_dmem_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_dmem_read || o_dmem_write) && !i_dmem_resp |=>
        $stable({o_dmem_read, o_dmem_write, o_dmem_addr, o_dmem_wdata}));

endmodule : lc3b_datapath

/* lc3b_hazard.sv */
`timescale 1ns/1ps

module lc3b_hazard (
    input  logic              i_imem_read,
    input  logic              i_imem_resp,
    input  logic              i_dmem_read,
    input  logic              i_dmem_write,
    input  logic              i_dmem_resp,
    input  logic              i_load_ex,
    input  lc3b_pkg::lc3b_reg i_dest_ex,
    input  lc3b_pkg::lc3b_reg i_src1_id,
    input  lc3b_pkg::lc3b_reg i_src2_id,
    input  logic              i_br_taken,
    output logic              o_load,
    output logic              o_stall_id,
    output logic              o_flush
);

    logic imem_wait;
    logic dmem_wait;
    logic use_hit;

    // any access still waiting for resp freezes the whole pipe
    assign imem_wait = i_imem_read & ~i_imem_resp;
    assign dmem_wait = (i_dmem_read | i_dmem_write) & ~i_dmem_resp;
    assign o_load    = ~(imem_wait | dmem_wait);

    // load in ex feeding the instruction in decode
    assign use_hit    = i_load_ex & (i_dest_ex == i_src1_id || i_dest_ex == i_src2_id);
    assign o_stall_id = o_load & use_hit;
    assign o_flush    = o_load & i_br_taken;

    // a branch in ex is never a load, so the two cannot meet
    always_comb begin
        a_flush_xor_stall: assert final (!(o_load && o_flush && o_stall_id));
    end

endmodule : lc3b_hazard

/* lc3b_forwarding.sv */
`timescale 1ns/1ps

module lc3b_forwarding (
    input  lc3b_pkg::lc3b_reg     i_src1_ex,
    input  lc3b_pkg::lc3b_reg     i_src2_ex,
    input  lc3b_pkg::lc3b_reg     i_dest_mem,
    input  lc3b_pkg::lc3b_reg     i_dest_wb,
    input  logic                  i_wr_mem,
    input  logic                  i_wr_wb,
    output lc3b_pkg::lc3b_fwd_sel o_fwd_a,
    output lc3b_pkg::lc3b_fwd_sel o_fwd_b
);

    import lc3b_pkg::*;

    // newest writer wins, mem is younger than wb
    function automatic lc3b_fwd_sel pick(lc3b_reg src);
        if (i_wr_mem && i_dest_mem == src) begin
            return fwd_mem;
        end else if (i_wr_wb && i_dest_wb == src) begin
            return fwd_wb;
        end
        return fwd_rf;
    endfunction

    assign o_fwd_a = pick(i_src1_ex);
    assign o_fwd_b = pick(i_src2_ex);

    always_comb begin
        a_no_stale_mem: assert final (i_wr_mem ||
            (o_fwd_a != fwd_mem && o_fwd_b != fwd_mem));
    end

endmodule : lc3b_forwarding

/* lc3b_pipe_reg.sv */
`timescale 1ns/1ps

module lc3b_pipe_reg #(
    parameter type      payload_t = logic [15:0],
    parameter payload_t BUBBLE    = '0
) (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_load,
    input  logic     i_bubble,
    input  payload_t i_d,
    output payload_t o_q
);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_q <= BUBBLE;
        end else if (i_load) begin
            o_q <= i_bubble ? BUBBLE : i_d;
        end
    end

    // bubble comes from hazard logic in other modules
    a_bubble_known: assert property (@(posedge clk) disable iff (!i_rst_n)
        !$isunknown(i_bubble));

endmodule : lc3b_pipe_reg

/* lc3b_regfile.sv */
`timescale 1ns/1ps

module lc3b_regfile (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_we,
    input  lc3b_pkg::lc3b_reg  i_dest,
    input  lc3b_pkg::lc3b_word i_wdata,
    input  lc3b_pkg::lc3b_reg  i_src_a,
    input  lc3b_pkg::lc3b_reg  i_src_b,
    output lc3b_pkg::lc3b_word o_a,
    output lc3b_pkg::lc3b_word o_b
);

    import lc3b_pkg::*;

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            regs <= '{default: '0};
        end else if (i_we) begin
            regs[i_dest] <= i_wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign o_a = (i_we && i_dest == i_src_a) ? i_wdata : regs[i_src_a];
    assign o_b = (i_we && i_dest == i_src_b) ? i_wdata : regs[i_src_b];

endmodule : lc3b_regfile

/* lc3b_control.sv */
`timescale 1ns/1ps

module lc3b_control (
    input  lc3b_pkg::lc3b_opcode       i_opcode,
    input  logic                       i_ir_5,
    output lc3b_pkg::lc3b_control_word o_cw
);

    import lc3b_pkg::*;

    always_comb begin
        o_cw = '0;
        case (i_opcode)
            op_add: begin
                o_cw.ex.aluop        = alu_add;
                o_cw.ex.alumux_imm   = i_ir_5;
                o_cw.wb.load_regfile = 1'b1;
                o_cw.wb.load_cc      = 1'b1;
            end
            op_and: begin
                o_cw.ex.aluop        = alu_and;
                o_cw.ex.alumux_imm   = i_ir_5;
                o_cw.wb.load_regfile = 1'b1;
                o_cw.wb.load_cc      = 1'b1;
            end
            op_not: begin
                o_cw.ex.aluop        = alu_not;
                o_cw.wb.load_regfile = 1'b1;
                o_cw.wb.load_cc      = 1'b1;
            end
            op_ldr: begin
                // base + offset6 through the alu
                o_cw.ex.aluop        = alu_add;
                o_cw.ex.alumux_imm   = 1'b1;
                o_cw.mem.d_read      = 1'b1;
                o_cw.wb.load_regfile = 1'b1;
                o_cw.wb.load_cc      = 1'b1;
                o_cw.wb.mdr_sel      = 1'b1;
            end
            op_str: begin
                o_cw.ex.aluop        = alu_add;
                o_cw.ex.alumux_imm   = 1'b1;
                o_cw.mem.d_write     = 1'b1;
            end
            op_br: begin
                o_cw.ex.branch = 1'b1;
            end
            op_lea: begin
                // lc-3b lea leaves cc alone
                o_cw.ex.aluop        = alu_pass;
                o_cw.ex.lea_sel      = 1'b1;
                o_cw.wb.load_regfile = 1'b1;
            end
            default: o_cw = '0;
        endcase
    end

endmodule : lc3b_control

/* lc3b_pkg.sv */
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    // full opcode map, unsupported ones decode as nop
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    // operand source for execute
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_mem,
        fwd_wb
    } lc3b_fwd_sel;

    typedef struct packed {
        lc3b_aluop aluop;
        logic      alumux_imm;
        logic      lea_sel;
        logic      branch;
    } lc3b_ctrl_ex;

    typedef struct packed {
        logic d_read;
        logic d_write;
    } lc3b_ctrl_mem;

    typedef struct packed {
        logic load_regfile;
        logic load_cc;
        // 0 selects alu, 1 selects mdr
        logic mdr_sel;
    } lc3b_ctrl_wb;

    typedef struct packed {
        lc3b_ctrl_ex  ex;
        lc3b_ctrl_mem mem;
        lc3b_ctrl_wb  wb;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_word pc_plus2;
        lc3b_word ir;
        logic     valid;
    } lc3b_if_id;

    typedef struct packed {
        lc3b_control_word cw;
        lc3b_word         pc_plus2;
        lc3b_reg          src1;
        lc3b_reg          src2;
        lc3b_reg          dest;
        lc3b_word         a;
        lc3b_word         b;
        lc3b_word         imm;
        lc3b_word         offset;
        lc3b_nzp          nzp;
    } lc3b_id_ex;

    typedef struct packed {
        lc3b_ctrl_mem mem;
        lc3b_ctrl_wb  wb;
        lc3b_reg      dest;
        lc3b_word     alu;
        lc3b_word     sdata;
    } lc3b_ex_mem;

    typedef struct packed {
        lc3b_ctrl_wb wb;
        lc3b_reg     dest;
        lc3b_word    alu;
        lc3b_word    mdr;
    } lc3b_mem_wb;

    localparam lc3b_word PC_RESET = 16'h0000;
    // BR with nzp 000, never taken
    localparam lc3b_word NOP_IR   = 16'h0000;
    localparam lc3b_nzp  CC_RESET = 3'b010;

endpackage : lc3b_pkg
